// ==== rtl/mmu_const_pkg.sv ====
package mmu_const_pkg;

    // fully associative, index width fixed by the entry count
    localparam int TLBNUM    = 16;
    localparam int TLB_IDX_W = 4;

    localparam int VPPN_W = 19;
    localparam int PPN_W  = 20;
    localparam int ASID_W = 10;

    // page size codes as held in the ps field
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd21;

    localparam int INV_OP_W = 5;

    localparam logic [INV_OP_W-1:0] INV_ALL0              = 5'd0;
    localparam logic [INV_OP_W-1:0] INV_ALL1              = 5'd1;
    localparam logic [INV_OP_W-1:0] INV_GLOBAL            = 5'd2;
    localparam logic [INV_OP_W-1:0] INV_NONGLOBAL         = 5'd3;
    localparam logic [INV_OP_W-1:0] INV_ASID              = 5'd4;
    localparam logic [INV_OP_W-1:0] INV_ASID_VA           = 5'd5;
    localparam logic [INV_OP_W-1:0] INV_GLOBAL_OR_ASID_VA = 5'd6;

    // maintenance command on maint_cmd
    localparam logic MAINT_WRITE      = 1'b0;
    localparam logic MAINT_INVALIDATE = 1'b1;

endpackage

// ==== rtl/mmu_types_pkg.sv ====
package mmu_types_pkg;

    import mmu_const_pkg::*;

    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_half_t;

    // one even/odd page pair
    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [5:0]        ps;
        logic              g;
        logic [ASID_W-1:0] asid;
        tlb_half_t         half0;
        tlb_half_t         half1;
    } tlb_entry_t;

    // same address, split per page size
    typedef union packed {
        struct packed {
            logic [VPPN_W-1:0] vppn;
            logic              odd;
            logic [PS_4K-1:0]  offset;
        } v4k;
        struct packed {
            logic [8:0]        vppn_hi;
            logic              odd;
            logic [PS_4M:0]    offset;
        } v4m;
    } tlb_vaddr_t;

endpackage

// ==== rtl/tlb_ifs.sv ====
interface tlb_array_if import mmu_const_pkg::*, mmu_types_pkg::*; ();

    tlb_entry_t entries [TLBNUM];

    modport owner (output entries);

    modport lookup (input entries);

endinterface

interface tlb_maint_if import mmu_const_pkg::*, mmu_types_pkg::*; ();

    // single-cycle strobes, never both high
    logic                 we;
    logic                 inv_valid;
    logic [TLB_IDX_W-1:0] index;
    tlb_entry_t           entry;
    logic [INV_OP_W-1:0]  inv_op;
    logic [ASID_W-1:0]    inv_asid;
    logic [VPPN_W-1:0]    inv_vppn;

    modport ctrl (output we, inv_valid, index, entry, inv_op, inv_asid, inv_vppn);

    modport array (input we, inv_valid, index, entry, inv_op, inv_asid, inv_vppn);

endinterface

// ==== rtl/tlb_entry_array.sv ====
module tlb_entry_array
    import mmu_const_pkg::*, mmu_types_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst_n,
    tlb_maint_if.array           m,
    tlb_array_if.owner           arr,
    input  logic [TLB_IDX_W-1:0] r_index,
    output tlb_entry_t           r_entry
);

    logic [TLBNUM-1:0] inv_hit;

    // which entries the current invalidate op selects
    always_comb begin
        tlb_entry_t ent;
        logic       asid_eq;
        logic       vppn_eq;
        for (int i = 0; i < TLBNUM; i++) begin
            ent     = arr.entries[i];
            asid_eq = ent.asid == m.inv_asid;
            // 4 MiB pages compare vppn[18:10] only
            if (ent.ps == PS_4M) begin
                vppn_eq = ent.vppn[VPPN_W-1:10] == m.inv_vppn[VPPN_W-1:10];
            end else begin
                vppn_eq = ent.vppn == m.inv_vppn;
            end
            case (m.inv_op)
                INV_ALL0, INV_ALL1: begin
                    inv_hit[i] = 1'b1;
                end
                INV_GLOBAL: begin
                    inv_hit[i] = ent.g;
                end
                INV_NONGLOBAL: begin
                    inv_hit[i] = !ent.g;
                end
                INV_ASID: begin
                    inv_hit[i] = !ent.g && asid_eq;
                end
                INV_ASID_VA: begin
                    inv_hit[i] = !ent.g && asid_eq && vppn_eq;
                end
                INV_GLOBAL_OR_ASID_VA: begin
                    inv_hit[i] = (ent.g || asid_eq) && vppn_eq;
                end
                default: begin
                    inv_hit[i] = 1'b0;
                end
            endcase
        end
    end

    // only the valid bit is reset
    always_ff @(posedge aclk) begin
        for (int i = 0; i < TLBNUM; i++) begin
            if (!rst_n) begin
                arr.entries[i].e <= 1'b0;
            end else if (m.we && m.index == TLB_IDX_W'(i)) begin
                arr.entries[i] <= m.entry;
            end else if (m.inv_valid && inv_hit[i]) begin
                arr.entries[i].e <= 1'b0;
            end
        end
    end

    assign r_entry = arr.entries[r_index];

endmodule

// ==== rtl/tlb_match.sv ====
module tlb_match
    import mmu_const_pkg::*, mmu_types_pkg::*;
(
    input  tlb_vaddr_t           va,
    input  logic [ASID_W-1:0]    asid,
    tlb_array_if.lookup          arr,
    output logic                 found,
    output logic [TLB_IDX_W-1:0] index,
    output logic [PPN_W-1:0]     ppn,
    output logic [5:0]           ps,
    output logic [1:0]           plv,
    output logic [1:0]           mat,
    output logic                 d,
    output logic                 v
);

    tlb_half_t sel;

    // scan downward so the lowest hitting index is kept
    always_comb begin
        tlb_entry_t ent;
        logic       vppn_eq;
        logic       odd;
        found = 1'b0;
        index = '0;
        ps    = '0;
        sel   = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            ent = arr.entries[i];
            if (ent.ps == PS_4M) begin
                vppn_eq = va.v4m.vppn_hi == ent.vppn[VPPN_W-1:10];
                odd     = va.v4m.odd;
            end else begin
                vppn_eq = va.v4k.vppn == ent.vppn;
                odd     = va.v4k.odd;
            end
            if (ent.e && (ent.g || ent.asid == asid) && vppn_eq) begin
                found = 1'b1;
                index = TLB_IDX_W'(i);
                ps    = ent.ps;
                sel   = odd ? ent.half1 : ent.half0;
            end
        end
    end

    // zero when nothing hits
    assign ppn = sel.ppn;
    assign plv = sel.plv;
    assign mat = sel.mat;
    assign d   = sel.d;
    assign v   = sel.v;

endmodule

// ==== rtl/tlb_maint_ctrl.sv ====
module tlb_maint_ctrl
    import mmu_const_pkg::*, mmu_types_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst_n,
    input  logic                 req,
    output logic                 ack,
    input  logic                 cmd,
    input  logic [TLB_IDX_W-1:0] index,
    input  logic [INV_OP_W-1:0]  inv_op,
    input  tlb_entry_t           wr_entry,
    tlb_maint_if.ctrl            m
);

    // idle when low, acked when high
    logic acked;
    logic fire;

    // accept only from idle, so one strobe per request
    assign fire = req && !acked;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            acked <= 1'b0;
        end else if (fire) begin
            acked <= 1'b1;
        end else if (acked && !req) begin
            acked <= 1'b0;
        end
    end

    assign ack = acked;

    assign m.we        = fire && cmd == MAINT_WRITE;
    assign m.inv_valid = fire && cmd == MAINT_INVALIDATE;

    // operands held stable by the requester until ack
    assign m.index    = index;
    assign m.entry    = wr_entry;
    assign m.inv_op   = inv_op;
    assign m.inv_asid = wr_entry.asid;
    assign m.inv_vppn = wr_entry.vppn;

endmodule

// ==== rtl/mmu_tlb_top.sv ====
module mmu_tlb_top
    import mmu_const_pkg::*, mmu_types_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst_n,
    // search port 0, fetch
    input  logic [31:0]          s0_va,
    input  logic [ASID_W-1:0]    s0_asid,
    output logic                 s0_found,
    output logic [TLB_IDX_W-1:0] s0_index,
    output logic [PPN_W-1:0]     s0_ppn,
    output logic [5:0]           s0_ps,
    output logic [1:0]           s0_plv,
    output logic [1:0]           s0_mat,
    output logic                 s0_d,
    output logic                 s0_v,
    // search port 1, load/store
    input  logic [31:0]          s1_va,
    input  logic [ASID_W-1:0]    s1_asid,
    output logic                 s1_found,
    output logic [TLB_IDX_W-1:0] s1_index,
    output logic [PPN_W-1:0]     s1_ppn,
    output logic [5:0]           s1_ps,
    output logic [1:0]           s1_plv,
    output logic [1:0]           s1_mat,
    output logic                 s1_d,
    output logic                 s1_v,
    // maintenance handshake
    input  logic                 maint_req,
    output logic                 maint_ack,
    input  logic                 maint_cmd,
    input  logic [TLB_IDX_W-1:0] maint_index,
    input  logic [INV_OP_W-1:0]  maint_inv_op,
    // write operands, also asid/vppn for invalidate
    input  logic                 w_e,
    input  logic [VPPN_W-1:0]    w_vppn,
    input  logic [5:0]           w_ps,
    input  logic [ASID_W-1:0]    w_asid,
    input  logic                 w_g,
    input  logic [PPN_W-1:0]     w_ppn0,
    input  logic [1:0]           w_plv0,
    input  logic [1:0]           w_mat0,
    input  logic                 w_d0,
    input  logic                 w_v0,
    input  logic [PPN_W-1:0]     w_ppn1,
    input  logic [1:0]           w_plv1,
    input  logic [1:0]           w_mat1,
    input  logic                 w_d1,
    input  logic                 w_v1,
    // read port
    input  logic [TLB_IDX_W-1:0] r_index,
    output logic                 r_e,
    output logic [VPPN_W-1:0]    r_vppn,
    output logic [5:0]           r_ps,
    output logic [ASID_W-1:0]    r_asid,
    output logic                 r_g,
    output logic [PPN_W-1:0]     r_ppn0,
    output logic [1:0]           r_plv0,
    output logic [1:0]           r_mat0,
    output logic                 r_d0,
    output logic                 r_v0,
    output logic [PPN_W-1:0]     r_ppn1,
    output logic [1:0]           r_plv1,
    output logic [1:0]           r_mat1,
    output logic                 r_d1,
    output logic                 r_v1
);

    tlb_entry_t wr_entry;
    tlb_entry_t rd_entry;

    tlb_array_if u_array_if ();
    tlb_maint_if u_maint_if ();

    assign wr_entry.e     = w_e;
    assign wr_entry.vppn  = w_vppn;
    assign wr_entry.ps    = w_ps;
    assign wr_entry.g     = w_g;
    assign wr_entry.asid  = w_asid;
    assign wr_entry.half0 = '{ppn: w_ppn0, plv: w_plv0, mat: w_mat0, d: w_d0, v: w_v0};
    assign wr_entry.half1 = '{ppn: w_ppn1, plv: w_plv1, mat: w_mat1, d: w_d1, v: w_v1};

    assign r_e    = rd_entry.e;
    assign r_vppn = rd_entry.vppn;
    assign r_ps   = rd_entry.ps;
    assign r_asid = rd_entry.asid;
    assign r_g    = rd_entry.g;
    assign r_ppn0 = rd_entry.half0.ppn;
    assign r_plv0 = rd_entry.half0.plv;
    assign r_mat0 = rd_entry.half0.mat;
    assign r_d0   = rd_entry.half0.d;
    assign r_v0   = rd_entry.half0.v;
    assign r_ppn1 = rd_entry.half1.ppn;
    assign r_plv1 = rd_entry.half1.plv;
    assign r_mat1 = rd_entry.half1.mat;
    assign r_d1   = rd_entry.half1.d;
    assign r_v1   = rd_entry.half1.v;

    tlb_maint_ctrl u_maint_ctrl (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .req      (maint_req),
        .ack      (maint_ack),
        .cmd      (maint_cmd),
        .index    (maint_index),
        .inv_op   (maint_inv_op),
        .wr_entry (wr_entry),
        .m        (u_maint_if.ctrl)
    );

    tlb_entry_array u_entry_array (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .m       (u_maint_if.array),
        .arr     (u_array_if.owner),
        .r_index (r_index),
        .r_entry (rd_entry)
    );

    tlb_match u_match_fetch (
        .va    (tlb_vaddr_t'(s0_va)),
        .asid  (s0_asid),
        .arr   (u_array_if.lookup),
        .found (s0_found),
        .index (s0_index),
        .ppn   (s0_ppn),
        .ps    (s0_ps),
        .plv   (s0_plv),
        .mat   (s0_mat),
        .d     (s0_d),
        .v     (s0_v)
    );

    tlb_match u_match_data (
        .va    (tlb_vaddr_t'(s1_va)),
        .asid  (s1_asid),
        .arr   (u_array_if.lookup),
        .found (s1_found),
        .index (s1_index),
        .ppn   (s1_ppn),
        .ps    (s1_ps),
        .plv   (s1_plv),
        .mat   (s1_mat),
        .d     (s1_d),
        .v     (s1_v)
    );

endmodule

// ==== tests/tb_mmu_tlb_asserts.sv ====
module tb_mmu_tlb_asserts
    import mmu_const_pkg::*, mmu_types_pkg::*;
(
    input logic                 aclk,
    input logic                 rst_n,
    input logic                 maint_req,
    input logic                 maint_ack,
    input logic                 maint_cmd,
    input logic [TLB_IDX_W-1:0] maint_index,
    input logic [INV_OP_W-1:0]  maint_inv_op,
    input tlb_entry_t           w_entry,
    input logic [31:0]          s0_va,
    input logic [ASID_W-1:0]    s0_asid,
    input logic [36:0]          s0_result,
    input logic [31:0]          s1_va,
    input logic [ASID_W-1:0]    s1_asid,
    input logic [36:0]          s1_result,
    input logic [TLB_IDX_W-1:0] r_index,
    input tlb_entry_t           r_entry
);

    tlb_entry_t        shadow [TLBNUM];
    logic [TLBNUM-1:0] written;
    logic              accept;
    logic [36:0]       s0_expect;
    logic [36:0]       s1_expect;
    tlb_entry_t        read_expect;
    int unsigned       fail_count = 0;

    // request seen by an idle controller
    assign accept = maint_req && !maint_ack;

    function automatic logic inv_selects(tlb_entry_t ent, logic [INV_OP_W-1:0] op,
                                         logic [ASID_W-1:0] asid, logic [VPPN_W-1:0] vppn);
        logic same_asid;
        logic same_va;
        logic sel;
        same_asid = ent.asid == asid;
        if (ent.ps == PS_4M) begin
            same_va = ent.vppn[VPPN_W-1:10] == vppn[VPPN_W-1:10];
        end else begin
            same_va = ent.vppn == vppn;
        end
        case (op)
            5'd0, 5'd1: sel = 1'b1;
            5'd2: sel = ent.g;
            5'd3: sel = !ent.g;
            5'd4: sel = !ent.g && same_asid;
            5'd5: sel = !ent.g && same_asid && same_va;
            5'd6: sel = (ent.g || same_asid) && same_va;
            default: sel = 1'b0;
        endcase
        return sel;
    endfunction

    // layout {found, index, ps, half}, first hit in ascending order
    function automatic logic [36:0] expected_search(logic [31:0] va, logic [ASID_W-1:0] asid);
        logic [36:0] res;
        logic        hit;
        logic        odd;
        tlb_entry_t  ent;
        res = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            ent = shadow[i];
            if (ent.ps == PS_4M) begin
                hit = va[31:23] == ent.vppn[VPPN_W-1:10];
                odd = va[22];
            end else begin
                hit = va[31:13] == ent.vppn;
                odd = va[12];
            end
            if (ent.e && (ent.g || ent.asid == asid) && hit && !res[36]) begin
                res = {1'b1, TLB_IDX_W'(i), ent.ps, odd ? ent.half1 : ent.half0};
            end
        end
        return res;
    endfunction

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < TLBNUM; i++) begin
                shadow[i].e <= 1'b0;
            end
            written <= '0;
        end else if (accept && maint_cmd == MAINT_WRITE) begin
            shadow[maint_index]  <= w_entry;
            written[maint_index] <= 1'b1;
        end else if (accept && maint_cmd == MAINT_INVALIDATE) begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (inv_selects(shadow[i], maint_inv_op, w_entry.asid, w_entry.vppn)) begin
                    shadow[i].e <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        s0_expect   = expected_search(s0_va, s0_asid);
        s1_expect   = expected_search(s1_va, s1_asid);
        read_expect = shadow[r_index];
    end

    a_reset_idle: assert property (@(posedge aclk)
        $rose(rst_n) |-> !maint_ack && !s0_result[36] && !s1_result[36])
        else begin
            $error("ERR %0t: outputs not idle after reset", $time);
            fail_count++;
        end

    a_ack_rise: assert property (@(posedge aclk) disable iff (!rst_n)
        maint_req && !maint_ack |=> maint_ack)
        else begin
            $error("ERR %0t: maint_ack did not rise one cycle after maint_req", $time);
            fail_count++;
        end

    a_ack_no_req: assert property (@(posedge aclk) disable iff (!rst_n)
        !maint_req && !maint_ack |=> !maint_ack)
        else begin
            $error("ERR %0t: maint_ack rose without maint_req", $time);
            fail_count++;
        end

    a_ack_fall: assert property (@(posedge aclk) disable iff (!rst_n)
        !maint_req && maint_ack |=> !maint_ack)
        else begin
            $error("ERR %0t: maint_ack did not fall one cycle after maint_req", $time);
            fail_count++;
        end

    a_search0: assert property (@(posedge aclk) disable iff (!rst_n)
        s0_result == s0_expect)
        else begin
            $error("ERR %0t: port 0 got %h, expected %h", $time, s0_result, s0_expect);
            fail_count++;
        end

    a_search1: assert property (@(posedge aclk) disable iff (!rst_n)
        s1_result == s1_expect)
        else begin
            $error("ERR %0t: port 1 got %h, expected %h", $time, s1_result, s1_expect);
            fail_count++;
        end

    a_read_e: assert property (@(posedge aclk) disable iff (!rst_n)
        r_entry.e == read_expect.e)
        else begin
            $error("ERR %0t: r_e wrong at index %0d", $time, r_index);
            fail_count++;
        end

    a_read_entry: assert property (@(posedge aclk) disable iff (!rst_n)
        written[r_index] |-> r_entry == read_expect)
        else begin
            $error("ERR %0t: read entry %0d got %h, expected %h", $time, r_index,
                   r_entry, read_expect);
            fail_count++;
        end

endmodule

bind mmu_tlb_top tb_mmu_tlb_asserts u_asserts (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .maint_req    (maint_req),
    .maint_ack    (maint_ack),
    .maint_cmd    (maint_cmd),
    .maint_index  (maint_index),
    .maint_inv_op (maint_inv_op),
    .w_entry      ({w_e, w_vppn, w_ps, w_g, w_asid, w_ppn0, w_plv0, w_mat0, w_d0, w_v0,
                    w_ppn1, w_plv1, w_mat1, w_d1, w_v1}),
    .s0_va        (s0_va),
    .s0_asid      (s0_asid),
    .s0_result    ({s0_found, s0_index, s0_ps, s0_ppn, s0_plv, s0_mat, s0_d, s0_v}),
    .s1_va        (s1_va),
    .s1_asid      (s1_asid),
    .s1_result    ({s1_found, s1_index, s1_ps, s1_ppn, s1_plv, s1_mat, s1_d, s1_v}),
    .r_index      (r_index),
    .r_entry      ({r_e, r_vppn, r_ps, r_g, r_asid, r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                    r_ppn1, r_plv1, r_mat1, r_d1, r_v1})
);

// ==== tests/tb_mmu_tlb.sv ====
module tb_mmu_tlb
    import mmu_const_pkg::*, mmu_types_pkg::*;
();

    // 9 fills of 16 entries, 8 invalidates, 18 sweeps of 16 searches
    localparam int N_WRITES      = 9 * TLBNUM;
    localparam int N_INVALIDATES = 8;
    localparam int N_SEARCHES    = 18 * TLBNUM;
    localparam int TIMEOUT_CYCLES = (N_WRITES + N_INVALIDATES) * 6 + N_SEARCHES + 16 + 200;

    logic                 aclk;
    logic                 rst_n;
    logic [31:0]          s0_va;
    logic [ASID_W-1:0]    s0_asid;
    logic [31:0]          s1_va;
    logic [ASID_W-1:0]    s1_asid;
    logic                 maint_req;
    logic                 maint_ack;
    logic                 maint_cmd;
    logic [TLB_IDX_W-1:0] maint_index;
    logic [INV_OP_W-1:0]  maint_inv_op;
    logic [TLB_IDX_W-1:0] r_index;
    tlb_entry_t           w;
    tlb_entry_t           wr_log [TLBNUM];
    logic [ASID_W-1:0]    asid_pool [4];
    logic [31:0]          rand_state;
    int                   cycle_count = 0;

    mmu_tlb_top UUT (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s0_va        (s0_va),
        .s0_asid      (s0_asid),
        .s0_found     (),
        .s0_index     (),
        .s0_ppn       (),
        .s0_ps        (),
        .s0_plv       (),
        .s0_mat       (),
        .s0_d         (),
        .s0_v         (),
        .s1_va        (s1_va),
        .s1_asid      (s1_asid),
        .s1_found     (),
        .s1_index     (),
        .s1_ppn       (),
        .s1_ps        (),
        .s1_plv       (),
        .s1_mat       (),
        .s1_d         (),
        .s1_v         (),
        .maint_req    (maint_req),
        .maint_ack    (maint_ack),
        .maint_cmd    (maint_cmd),
        .maint_index  (maint_index),
        .maint_inv_op (maint_inv_op),
        .w_e          (w.e),
        .w_vppn       (w.vppn),
        .w_ps         (w.ps),
        .w_asid       (w.asid),
        .w_g          (w.g),
        .w_ppn0       (w.half0.ppn),
        .w_plv0       (w.half0.plv),
        .w_mat0       (w.half0.mat),
        .w_d0         (w.half0.d),
        .w_v0         (w.half0.v),
        .w_ppn1       (w.half1.ppn),
        .w_plv1       (w.half1.plv),
        .w_mat1       (w.half1.mat),
        .w_d1         (w.half1.d),
        .w_v1         (w.half1.v),
        .r_index      (r_index),
        .r_e          (),
        .r_vppn       (),
        .r_ps         (),
        .r_asid       (),
        .r_g          (),
        .r_ppn0       (),
        .r_plv0       (),
        .r_mat0       (),
        .r_d0         (),
        .r_v0         (),
        .r_ppn1       (),
        .r_plv1       (),
        .r_mat1       (),
        .r_d1         (),
        .r_v1         ()
    );

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // stop at the first assertion that fired
    always @(posedge aclk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "an assertion on the DUT failed");
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state ^ (rand_state >> 15);
    endfunction

    function automatic logic [31:0] va_for(tlb_entry_t ent, logic odd, logic [31:0] offs);
        logic [31:0] va;
        if (ent.ps == PS_4M) begin
            va = {ent.vppn[VPPN_W-1:10], odd, offs[21:0]};
        end else begin
            va = {ent.vppn, odd, offs[11:0]};
        end
        return va;
    endfunction

    // every task starts and ends 5 units after a rising edge
    task automatic run_handshake();
        maint_req = 1'b1;
        do begin
            @(posedge aclk);
            #5;
        end while (!maint_ack);
        maint_req = 1'b0;
        do begin
            @(posedge aclk);
            #5;
        end while (maint_ack);
    endtask

    task automatic write_entry(input int idx, input tlb_entry_t ent);
        maint_cmd   = MAINT_WRITE;
        maint_index = TLB_IDX_W'(idx);
        w           = ent;
        wr_log[idx] = ent;
        run_handshake();
    endtask

    task automatic write_random(input int idx);
        tlb_entry_t  ent;
        logic [31:0] r;
        ent      = tlb_entry_t'({next_rand(), next_rand(), next_rand()});
        r        = next_rand();
        ent.e    = r[31:29] != 3'b000;
        ent.ps   = r[28] ? PS_4M : PS_4K;
        ent.g    = r[27:26] == 2'b00;
        ent.asid = asid_pool[r[25:24]];
        // alias a lower entry so the lowest index has to win
        if (idx >= 8 && r[23:22] == 2'b00) begin
            ent.vppn = wr_log[idx-8].vppn;
            ent.ps   = wr_log[idx-8].ps;
            ent.asid = wr_log[idx-8].asid;
        end
        write_entry(idx, ent);
    endtask

    task automatic fill_all();
        for (int i = 0; i < TLBNUM; i++) begin
            write_random(i);
        end
    endtask

    task automatic invalidate(input logic [INV_OP_W-1:0] op, input int src);
        maint_cmd    = MAINT_INVALIDATE;
        maint_inv_op = op;
        w.asid       = wr_log[src].asid;
        w.vppn       = wr_log[src].vppn;
        run_handshake();
    endtask

    // port 0 aims at entry i, port 1 at a mirrored entry or a random address
    task automatic search_sweep();
        tlb_entry_t  ent;
        logic [31:0] r;
        for (int i = 0; i < TLBNUM; i++) begin
            r       = next_rand();
            ent     = wr_log[i];
            s0_va   = va_for(ent, r[0], next_rand());
            s0_asid = ent.g ? asid_pool[r[5:4]] : ent.asid;
            if (r[1]) begin
                s1_va   = va_for(wr_log[TLBNUM-1-i], !r[0], next_rand());
                s1_asid = wr_log[TLBNUM-1-i].asid;
            end else begin
                s1_va   = next_rand();
                s1_asid = asid_pool[r[3:2]];
            end
            r_index = TLB_IDX_W'(i);
            @(posedge aclk);
            #5;
        end
    endtask

    initial begin
        aclk         = 1'b0;
        rst_n        = 1'b0;
        s0_va        = '0;
        s0_asid      = '0;
        s1_va        = '0;
        s1_asid      = '0;
        maint_req    = 1'b0;
        maint_cmd    = MAINT_WRITE;
        maint_index  = '0;
        maint_inv_op = '0;
        r_index      = '0;
        w            = '0;
        rand_state   = 32'h83433532;
        for (int i = 0; i < TLBNUM; i++) begin
            wr_log[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            asid_pool[i] = ASID_W'(next_rand());
        end
        repeat (16) @(posedge aclk);
        #5;
        rst_n = 1'b1;
        search_sweep();
        fill_all();
        search_sweep();
        for (int op = 0; op < 8; op++) begin
            fill_all();
            search_sweep();
            // pass 7 uses an undefined code
            invalidate((op == 7) ? 5'd9 : INV_OP_W'(op), int'(next_rand() >> 28));
            search_sweep();
        end
        repeat (2) @(posedge aclk);
        #5;
        if (UUT.u_asserts.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures were reported");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== mmu_tlb.f ====
rtl/mmu_const_pkg.sv
rtl/mmu_types_pkg.sv
rtl/tlb_ifs.sv
rtl/tlb_entry_array.sv
rtl/tlb_match.sv
rtl/tlb_maint_ctrl.sv
rtl/mmu_tlb_top.sv
tests/tb_mmu_tlb_asserts.sv
tests/tb_mmu_tlb.sv

// ==== Bender.yml ====
package:
  name: mmu_tlb

sources:
  - rtl/mmu_const_pkg.sv
  - rtl/mmu_types_pkg.sv
  - rtl/tlb_ifs.sv
  - rtl/tlb_entry_array.sv
  - rtl/tlb_match.sv
  - rtl/tlb_maint_ctrl.sv
  - rtl/mmu_tlb_top.sv
  - target: test
    files:
      - tests/tb_mmu_tlb_asserts.sv
      - tests/tb_mmu_tlb.sv
